// File: lane_serializer.f
+incdir+.
lane_ser_pkg.sv
lane_ser_router.sv
lane_ser_lane.sv
lane_ser_arbiter.sv
lane_ser_top.sv
lane_ser_tb.sv

// File: lane_ser_tb.sv
/*
 * Lane serializer testbench
 * Table-driven flits with per-lane expected slices, random pop back-pressure,
 * packet interleave and stall stability checks
 */

`timescale 1ns/100ps

`include "lane_ser_cfg.svh"

module lane_ser_tb;

  import lane_ser_pkg::*;

  localparam int NumFlits     = 13;
  localparam int PushW        = `LANE_SER_PUSH_WIDTH;
  localparam int PopW         = `LANE_SER_POP_WIDTH;
  localparam int MaxSlices    = 64;
  localparam int PushTimeout  = 200;
  localparam int DrainTimeout = 2000;

  // Clock starts low without an edge at time zero
  logic clk = 1'b0;
  logic rst_n;
  logic push_valid;
  push_data_t push_data;
  logic push_last;
  slice_idx_t push_dont_care;
  meta_t push_meta;
  lane_id_t push_lane;
  logic push_ready;
  logic pop_ready;
  logic pop_valid;
  pop_data_t pop_data;
  logic pop_last;
  meta_t pop_meta;
  lane_id_t pop_lane;

  // Stimulus table; the extra name slot is the reset test
  string      tst_name [NumFlits+1];
  lane_id_t   tst_lane [NumFlits];
  push_data_t tst_data [NumFlits];
  logic       tst_last [NumFlits];
  slice_idx_t tst_dc   [NumFlits];
  meta_t      tst_meta [NumFlits];
  int         flit_errs [NumFlits+1];

  // Expected slices in table order, read per lane through lane_ptr
  pop_data_t exp_data  [MaxSlices];
  meta_t     exp_meta  [MaxSlices];
  logic      exp_last  [MaxSlices];
  logic      exp_final [MaxSlices];
  lane_id_t  exp_lane  [MaxSlices];
  int        exp_flit  [MaxSlices];
  int        lane_ptr  [`LANE_SER_NUM_LANES];

  int total_slices = 0;
  int slices_seen = 0;
  int errors = 0;
  int tests_done = 0;
  int tests_failed = 0;
  bit timed_out = 1'b0;
  logic [31:0] lfsr_state = 32'hd886_9419;

  // Stall tracking and packet lock tracking on the pop side
  bit held = 1'b0;
  pop_data_t held_data;
  lane_id_t held_lane;
  bit pkt_open = 1'b0;
  lane_id_t open_lane;

  lane_ser_top DUT (.*);

  initial begin
    forever #2 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int find_next(input int lane, input int from);
    for (int i = from; i < total_slices; i++) begin
      if (exp_lane[i] == lane) return i;
    end
    return total_slices;
  endfunction

  task automatic set_flit(input int f, input string name, input int lane,
                          input logic [31:0] data, input logic last,
                          input int dc, input int meta);
    tst_name[f] = name;
    tst_lane[f] = lane_id_t'(lane);
    tst_data[f] = data;
    tst_last[f] = last;
    tst_dc[f]   = slice_idx_t'(dc);
    tst_meta[f] = meta_t'(meta);
  endtask

  // Each other-lane flit between two flits of an open packet goes to an empty lane
  task automatic load_table();
    tst_name[NumFlits] = "reset_state";
    set_flit(0,  "l0_pkt_a_f0", 0, 32'h0123_4567, 1'b0, 0, 1);
    set_flit(1,  "l1_dc1",      1, 32'hdead_beef, 1'b1, 1, 2);
    set_flit(2,  "l2_dc3",      2, 32'hcafe_f00d, 1'b1, 3, 3);
    set_flit(3,  "l0_pkt_a_f1", 0, 32'h89ab_cdef, 1'b1, 0, 1);
    set_flit(4,  "l3_pkt_d_f0", 3, 32'h1122_3344, 1'b0, 0, 4);
    set_flit(5,  "l0_dc2",      0, 32'h5566_7788, 1'b1, 2, 5);
    set_flit(6,  "l3_pkt_d_f1", 3, 32'h99aa_bbcc, 1'b1, 2, 4);
    set_flit(7,  "l2_pkt_f_f0", 2, 32'h0f1e_2d3c, 1'b0, 0, 6);
    set_flit(8,  "l2_pkt_f_f1", 2, 32'h4b5a_6978, 1'b0, 0, 6);
    set_flit(9,  "l2_pkt_f_f2", 2, 32'h8796_a5b4, 1'b1, 1, 6);
    set_flit(10, "l1_full",     1, 32'hc3d2_e1f0, 1'b1, 0, 7);
    set_flit(11, "l3_dc3",      3, 32'h7e57_ab1e, 1'b1, 3, 0);
    set_flit(12, "l0_full",     0, 32'hfeed_face, 1'b1, 0, 2);
  endtask

  // Most significant slice first; a last flit drops dc slices at its tail
  task automatic build_expected();
    int n;
    for (int f = 0; f < NumFlits; f++) begin
      n = tst_last[f] ? (PushW / PopW) - int'(tst_dc[f]) : PushW / PopW;
      for (int j = 0; j < n; j++) begin
        exp_data[total_slices]  = tst_data[f][PushW-1-j*PopW -: PopW];
        exp_meta[total_slices]  = tst_meta[f];
        exp_last[total_slices]  = tst_last[f] && (j == n - 1);
        exp_final[total_slices] = (j == n - 1);
        exp_lane[total_slices]  = tst_lane[f];
        exp_flit[total_slices]  = f;
        total_slices++;
      end
    end
    for (int l = 0; l < `LANE_SER_NUM_LANES; l++) lane_ptr[l] = find_next(l, 0);
  endtask

  task automatic report_mismatch(input int f, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s %s: expected %h, actual %h", tst_name[f], what, exp, act);
    errors++;
    flit_errs[f]++;
  endtask

  task automatic report_test(input int f);
    tests_done++;
    if (flit_errs[f] != 0) begin
      tests_failed++;
      $display("FAIL %s (%0d errors)", tst_name[f], flit_errs[f]);
    end else begin
      $display("PASS %s", tst_name[f]);
    end
  endtask

  // pop_ready takes one fresh LFSR bit per cycle
  always @(negedge clk) begin
    lfsr_state = lfsr_next(lfsr_state);
    pop_ready  = lfsr_state[0];
  end

  // --------------------
  // Pop monitor
  // --------------------
  always @(posedge clk) begin : monitor
    int l;
    int idx;
    if (rst_n) begin
      // A stalled slice must still be offered, unchanged, on the same lane
      if (held) begin
        idx = lane_ptr[held_lane];
        if (idx >= total_slices) idx = 0;
        if (!pop_valid) report_mismatch(exp_flit[idx], "stall_valid", 1, pop_valid);
        if (pop_data !== held_data)
          report_mismatch(exp_flit[idx], "stall_data", held_data, pop_data);
        if (pop_lane !== held_lane)
          report_mismatch(exp_flit[idx], "stall_lane", held_lane, pop_lane);
      end
      held      = pop_valid && !pop_ready;
      held_data = pop_data;
      held_lane = pop_lane;
      if (pop_valid && pop_ready) begin
        l   = pop_lane;
        idx = lane_ptr[l];
        if (idx >= total_slices) begin
          $display("Slice %h arrived on lane %0d with no flit pending there", pop_data, l);
          errors++;
        end else begin
          if (pkt_open && pop_lane !== open_lane)
            report_mismatch(exp_flit[idx], "interleave_lane", open_lane, pop_lane);
          if (pop_data !== exp_data[idx])
            report_mismatch(exp_flit[idx], "data", exp_data[idx], pop_data);
          if (pop_meta !== exp_meta[idx])
            report_mismatch(exp_flit[idx], "meta", exp_meta[idx], pop_meta);
          if (pop_last !== exp_last[idx])
            report_mismatch(exp_flit[idx], "last", exp_last[idx], pop_last);
          pkt_open  = !pop_last;
          open_lane = pop_lane;
          slices_seen++;
          lane_ptr[l] = find_next(l, idx + 1);
          if (exp_final[idx]) report_test(exp_flit[idx]);
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    int cnt;
    bit accepted;
    rst_n = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    push_last = 1'b0;
    push_dont_care = '0;
    push_meta = '0;
    push_lane = '0;
    pop_ready = 1'b0;
    for (int f = 0; f <= NumFlits; f++) flit_errs[f] = 0;
    load_table();
    build_expected();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle state before any flit is offered
    @(posedge clk);
    if (pop_valid !== 1'b0) report_mismatch(NumFlits, "pop_valid", 0, pop_valid);
    if (push_ready !== 1'b1) report_mismatch(NumFlits, "push_ready", 1, push_ready);
    report_test(NumFlits);

    // Flits go back to back; a flit is held until push_ready is seen at an edge
    @(negedge clk);
    for (int f = 0; f < NumFlits; f++) begin
      push_valid     = 1'b1;
      push_data      = tst_data[f];
      push_last      = tst_last[f];
      push_dont_care = tst_dc[f];
      push_meta      = tst_meta[f];
      push_lane      = tst_lane[f];
      accepted = 1'b0;
      cnt = 0;
      while (!accepted && cnt < PushTimeout) begin
        @(posedge clk);
        accepted = push_ready;
        cnt++;
      end
      @(negedge clk);
      if (!accepted) begin
        $display("Timed out waiting for push_ready on flit %s", tst_name[f]);
        timed_out = 1'b1;
        break;
      end
    end
    push_valid = 1'b0;

    cnt = 0;
    while (!timed_out && slices_seen < total_slices && cnt < DrainTimeout) begin
      @(posedge clk);
      cnt++;
    end
    if (!timed_out && slices_seen < total_slices) begin
      $display("Timed out draining, %0d of %0d slices seen", slices_seen, total_slices);
      timed_out = 1'b1;
    end
    // A few idle cycles so that any stray slice is caught by the monitor
    repeat (10) @(posedge clk);

    $display("Tests: %0d finished, %0d failed, %0d check errors",
             tests_done, tests_failed, errors);
    if (timed_out || errors != 0 || tests_done != NumFlits + 1) begin
      $display("Some tests failed");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

// File: lane_ser_top.sv
/*
 * Multi-lane flit serializer top level
 * Router, one serializer lane per lane number, and the packet arbiter
 */

`timescale 1ns/100ps

`include "lane_ser_cfg.svh"

module lane_ser_top #(
  parameter bit serialize_msb_first = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_valid,
  input  lane_ser_pkg::push_data_t push_data,
  input  logic                     push_last,
  input  lane_ser_pkg::slice_idx_t push_dont_care,
  input  lane_ser_pkg::meta_t      push_meta,
  input  lane_ser_pkg::lane_id_t   push_lane,
  output logic                     push_ready,
  input  logic                     pop_ready,
  output logic                     pop_valid,
  output lane_ser_pkg::pop_data_t  pop_data,
  output logic                     pop_last,
  output lane_ser_pkg::meta_t      pop_meta,
  output lane_ser_pkg::lane_id_t   pop_lane
);

  import lane_ser_pkg::*;

  localparam int NumLanes = `LANE_SER_NUM_LANES;

  // Router to lanes
  logic [NumLanes-1:0] lane_in_valid;
  logic [NumLanes-1:0] lane_in_ready;

  // Lanes to arbiter
  logic [NumLanes-1:0] lane_out_valid;
  logic [NumLanes-1:0] lane_out_ready;
  logic [NumLanes-1:0] lane_out_last;
  pop_data_t           lane_out_data [NumLanes];
  meta_t               lane_out_meta [NumLanes];

  lane_ser_router u_router (
    .push_valid    (push_valid),
    .push_lane     (push_lane),
    .lane_in_ready (lane_in_ready),
    .push_ready    (push_ready),
    .lane_in_valid (lane_in_valid)
  );

  // Flit fields are broadcast; only the routed valid differs per lane
  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane
    lane_ser_lane #(
      .serialize_msb_first (serialize_msb_first)
    ) u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (lane_in_valid[i]),
      .in_data      (push_data),
      .in_last      (push_last),
      .in_dont_care (push_dont_care),
      .in_meta      (push_meta),
      .out_ready    (lane_out_ready[i]),
      .in_ready     (lane_in_ready[i]),
      .out_valid    (lane_out_valid[i]),
      .out_data     (lane_out_data[i]),
      .out_last     (lane_out_last[i]),
      .out_meta     (lane_out_meta[i])
    );
  end

  lane_ser_arbiter u_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_out_valid (lane_out_valid),
    .lane_out_data  (lane_out_data),
    .lane_out_last  (lane_out_last),
    .lane_out_meta  (lane_out_meta),
    .pop_ready      (pop_ready),
    .lane_out_ready (lane_out_ready),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .pop_last       (pop_last),
    .pop_meta       (pop_meta),
    .pop_lane       (pop_lane)
  );

endmodule

// File: lane_ser_arbiter.sv
/*
 * Lane serializer output arbiter
 * Round-robin over lanes with the grant held for a whole packet, so
 * slices of different packets never interleave on the pop side
 */

`timescale 1ns/100ps

`include "lane_ser_cfg.svh"

module lane_ser_arbiter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [`LANE_SER_NUM_LANES-1:0]   lane_out_valid,
  input  lane_ser_pkg::pop_data_t          lane_out_data [`LANE_SER_NUM_LANES],
  input  logic [`LANE_SER_NUM_LANES-1:0]   lane_out_last,
  input  lane_ser_pkg::meta_t              lane_out_meta [`LANE_SER_NUM_LANES],
  input  logic                             pop_ready,
  output logic [`LANE_SER_NUM_LANES-1:0]   lane_out_ready,
  output logic                             pop_valid,
  output lane_ser_pkg::pop_data_t          pop_data,
  output logic                             pop_last,
  output lane_ser_pkg::meta_t              pop_meta,
  output lane_ser_pkg::lane_id_t           pop_lane
);

  import lane_ser_pkg::*;

  localparam int NumLanes = `LANE_SER_NUM_LANES;

  arb_state_e state;
  arb_state_e state_next;
  lane_id_t   grant_q;
  lane_id_t   rr_ptr;
  lane_id_t   pick;
  logic       pick_found;
  lane_id_t   sel;
  logic       pop_fire;

  // --------------------
  // Rotating priority
  // --------------------
  // Search starts just after the last granted lane and wraps around to it
  always_comb begin
    lane_id_t cand;
    pick       = rr_ptr;
    pick_found = 1'b0;
    for (int i = 1; i <= NumLanes; i++) begin
      cand = lane_id_t'((int'(rr_ptr) + i) % NumLanes);
      if (!pick_found && lane_out_valid[cand]) begin
        pick       = cand;
        pick_found = 1'b1;
      end
    end
  end

  // A locked packet keeps its lane; otherwise the search result passes through
  assign sel = (state == ARB_LOCKED) ? grant_q : pick;

  assign pop_valid = lane_out_valid[sel];
  assign pop_data  = lane_out_data[sel];
  assign pop_last  = lane_out_last[sel];
  assign pop_meta  = lane_out_meta[sel];
  assign pop_lane  = sel;
  assign pop_fire  = pop_valid && pop_ready;

  // Pop ready goes back to the selected lane only
  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      lane_out_ready[i] = pop_ready && (sel == lane_id_t'(i));
    end
  end

  // --------------------
  // Packet lock FSM
  // --------------------
  // Locking also on a stalled first slice keeps pop_data stable under back-pressure
  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE:   if (pop_valid && !(pop_fire && pop_last)) state_next = ARB_LOCKED;
      ARB_LOCKED: if (pop_fire && pop_last) state_next = ARB_IDLE;
      default:    state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ARB_IDLE;
      grant_q <= '0;
      rr_ptr  <= '0;
    end else begin
      state <= state_next;
      if (state == ARB_IDLE && pop_valid) begin
        grant_q <= pick;
      end
      // Pointer moves once the packet on the selected lane has ended
      if (pop_fire && pop_last) begin
        rr_ptr <= sel;
      end
    end
  end

endmodule

// File: lane_ser_lane.sv
/*
 * Lane serializer lane
 * Holds one push flit and emits it as pop slices, ending early on the
 * last flit of a packet when it carries don't-care slices at its tail
 */

`timescale 1ns/100ps

module lane_ser_lane #(
  parameter bit serialize_msb_first = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  lane_ser_pkg::push_data_t in_data,
  input  logic                     in_last,
  input  lane_ser_pkg::slice_idx_t in_dont_care,
  input  lane_ser_pkg::meta_t      in_meta,
  input  logic                     out_ready,
  output logic                     in_ready,
  output logic                     out_valid,
  output lane_ser_pkg::pop_data_t  out_data,
  output logic                     out_last,
  output lane_ser_pkg::meta_t      out_meta
);

  import lane_ser_pkg::*;

  localparam int PopWidth = $bits(pop_data_t);
  localparam slice_idx_t LastIdx = slice_idx_t'(SER_RATIO - 1);

  // Holding register for the current flit
  push_data_t flit_data;
  logic       flit_last;
  slice_idx_t flit_dont_care;
  meta_t      flit_meta;
  logic       full;

  // Slice sequencing
  slice_idx_t slice_cnt;
  slice_idx_t slice_sel;
  slice_idx_t final_idx;
  logic       final_slice;
  logic       in_fire;
  logic       out_fire;

  // --------------------
  // Handshakes
  // --------------------
  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  // The register refills in the same cycle its final slice leaves, so a
  // busy lane keeps emitting one slice per cycle
  assign in_ready = !full || (out_fire && final_slice);

  // Only a last flit may stop before the top slice index
  assign final_idx   = flit_last ? (LastIdx - flit_dont_care) : LastIdx;
  assign final_slice = (slice_cnt == final_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_fire && final_slice) begin
      full <= 1'b0;
    end
  end

  // Counter advances per accepted slice and restarts on the final one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slice_cnt <= '0;
    end else if (out_fire) begin
      slice_cnt <= final_slice ? '0 : slice_cnt + 1'b1;
    end
  end

  // Holding register loads the whole flit on acceptance
  always_ff @(posedge clk) begin
    if (in_fire) begin
      flit_data      <= in_data;
      flit_last      <= in_last;
      flit_dont_care <= in_dont_care;
      flit_meta      <= in_meta;
    end
  end

  // --------------------
  // Slice mux
  // --------------------
  // With MSB first, count 0 maps to the top slice of the flit
  assign slice_sel = serialize_msb_first ? (LastIdx - slice_cnt) : slice_cnt;
  assign out_data  = flit_data[slice_sel*PopWidth +: PopWidth];

  assign out_valid = full;
  // Packet end is flagged only on the final slice of a last flit
  assign out_last  = flit_last && final_slice;
  assign out_meta  = flit_meta;

endmodule

// File: lane_ser_router.sv
/*
 * Lane serializer input router
 * Decodes the lane number of a push flit into a one-hot lane valid and
 * returns the addressed lane's ready as push_ready
 */

`timescale 1ns/100ps

`include "lane_ser_cfg.svh"

module lane_ser_router (
  input  logic                             push_valid,
  input  lane_ser_pkg::lane_id_t           push_lane,
  input  logic [`LANE_SER_NUM_LANES-1:0]   lane_in_ready,
  output logic                             push_ready,
  output logic [`LANE_SER_NUM_LANES-1:0]   lane_in_valid
);

  import lane_ser_pkg::*;

  localparam int NumLanes = `LANE_SER_NUM_LANES;

  // One-hot match of the push lane number against every lane
  logic [NumLanes-1:0] lane_hit;

  // --------------------
  // Lane decode
  // --------------------
  // A lane number outside the lane range hits nothing, so the flit is
  // never accepted and push_ready stays low
  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      lane_hit[i] = (push_lane == lane_id_t'(i));
    end
  end

  // Only the addressed lane sees a valid; the flit fields go to all lanes
  assign lane_in_valid = lane_hit & {NumLanes{push_valid}};

  // Ready of the addressed lane only, independent of push_valid
  always_comb begin
    push_ready = 1'b0;
    for (int i = 0; i < NumLanes; i++) begin
      push_ready = push_ready | (lane_hit[i] & lane_in_ready[i]);
    end
  end

endmodule

// File: lane_ser_pkg.sv
/*
 * Lane serializer package
 * Vector types sized from the configuration macros, and the arbiter state
 */

`include "lane_ser_cfg.svh"

package lane_ser_pkg;

  // Number of pop slices carried by one push flit
  localparam int SER_RATIO = `LANE_SER_PUSH_WIDTH / `LANE_SER_POP_WIDTH;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [`LANE_SER_PUSH_WIDTH-1:0] push_data_t;
  typedef logic [`LANE_SER_POP_WIDTH-1:0] pop_data_t;
  typedef logic [`LANE_SER_META_WIDTH-1:0] meta_t;
  typedef logic [$clog2(`LANE_SER_NUM_LANES)-1:0] lane_id_t;

  // Slice index within a flit, also used for the don't-care count
  typedef logic [$clog2(SER_RATIO)-1:0] slice_idx_t;

  // Packet-locked arbiter states
  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_e;

endpackage

// File: lane_ser_cfg.svh
/*
 * Lane serializer configuration
 * Bus widths and lane count used by the package and the RTL
 */

`ifndef LANE_SER_CFG_SVH
`define LANE_SER_CFG_SVH

// Width of one wide flit on the push side
// Must be a multiple of the pop width and at least twice as wide
`define LANE_SER_PUSH_WIDTH 32

// Width of one narrow slice on the pop side
`define LANE_SER_POP_WIDTH 8

// Sideband metadata, copied onto every slice and never serialized
`define LANE_SER_META_WIDTH 3

// Number of serializer lanes behind the input router
`define LANE_SER_NUM_LANES 4

`endif
